// File: common/vecExpandPkg.sv
`default_nettype none

// ============================================================
// Shared types for the vector expansion stage
// ============================================================

package vecExpandPkg;

	// Most elements a single vector instruction can be split into
	localparam int MAX_ELEMS = 8;

	// Architectural register number as seen by decode
	typedef logic [5:0] archReg_t;

	// Element index inside one vector register group
	typedef logic [2:0] elemIdx_t;

	// Architectural register followed by the element index
	typedef logic [8:0] elemReg_t;

	// Program counter of an instruction in the fetch group
	typedef logic [31:0] pcAddr_t;

	// Microcode address, tagged with the slot number per micro-op
	typedef logic [11:0] mcAddr_t;

	// Vector length as delivered with the group, may exceed MAX_ELEMS
	typedef logic [4:0] vecLen_t;

	// Element count of one slot, 0 through MAX_ELEMS
	typedef logic [3:0] elemCnt_t;

	// Micro-op count of a whole group, enough for four full slots
	typedef logic [5:0] uopCnt_t;

	// ============================================================
	// Instruction side
	// ============================================================

	// A register field and the flag that marks it as a vector register
	typedef struct packed {
		logic     isVec;
		archReg_t regNum;
	} regSpec_t;

	// Decoded instruction as it leaves the decoder
	typedef struct packed {
		logic [15:0] opcode;
		regSpec_t    rt;
		regSpec_t    ra;
		regSpec_t    rb;
		regSpec_t    rc;
	} exInstr_t;

	// ============================================================
	// Micro-op side
	// ============================================================

	// Expanded register field, the flag travels along for rename
	typedef struct packed {
		logic     isVec;
		elemReg_t elemReg;
	} microReg_t;

	// One issued micro-op
	typedef struct packed {
		logic [15:0] opcode;
		microReg_t   rt;
		microReg_t   ra;
		microReg_t   rb;
		microReg_t   rc;
		elemIdx_t    elemIdx;
		pcAddr_t     pc;
		mcAddr_t     mip;
	} microOp_t;

endpackage

`default_nettype wire

// File: expand/groupLatch.sv
`timescale 1ns/1ns
`default_nettype none

module groupLatch #(
	parameter int SLOTS = 4
) (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic                                 groupValid,
	input  vecExpandPkg::vecLen_t                vl,
	input  vecExpandPkg::mcAddr_t                mip,
	input  vecExpandPkg::pcAddr_t  [SLOTS-1:0]   pcs,
	input  vecExpandPkg::exInstr_t [SLOTS-1:0]   instrs,
	input  logic                                 doneStrobe,
	output logic                                 latchValid,
	output vecExpandPkg::elemCnt_t               latVl,
	output vecExpandPkg::mcAddr_t                latMip,
	output vecExpandPkg::pcAddr_t  [SLOTS-1:0]   latPcs,
	output vecExpandPkg::exInstr_t [SLOTS-1:0]   latInstrs,
	output logic                                 inFlight
);
	import vecExpandPkg::*;

	logic     accept;
	elemCnt_t clampedVl;

	// A new group is only taken while nothing is in flight
	assign accept = groupValid && !inFlight;

	// Lengths beyond the element limit saturate, zero stays zero
	assign clampedVl = (vl > vecLen_t'(MAX_ELEMS)) ? elemCnt_t'(MAX_ELEMS) : elemCnt_t'(vl);

	// ============================================================
	// Control state
	// ============================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			inFlight   <= 1'b0;
			latchValid <= 1'b0;
		end else begin
			latchValid <= accept;
			// The issue side releases the group with its last micro-op
			if (accept)
				inFlight <= 1'b1;
			else if (doneStrobe)
				inFlight <= 1'b0;
		end
	end

	// Group payload, held until the next accepted strobe
	always_ff @(posedge clk) begin
		if (accept) begin
			latVl     <= clampedVl;
			latMip    <= mip;
			latPcs    <= pcs;
			latInstrs <= instrs;
		end
	end

	// The stage has no queue, a strobe during a group would be lost
	noStrobeWhileBusy: assert property (@(posedge clk) disable iff (rst)
		groupValid |-> !inFlight)
		else $error("groupLatch: group strobed while a group is in flight");

endmodule

`default_nettype wire

// File: expand/slotExpander.sv
`timescale 1ns/1ns
`default_nettype none

module slotExpander #(
	parameter int SLOT_INDEX = 0
) (
	input  vecExpandPkg::exInstr_t                          instr,
	input  vecExpandPkg::pcAddr_t                           pc,
	input  vecExpandPkg::mcAddr_t                           mip,
	input  vecExpandPkg::elemCnt_t                          vl,
	output vecExpandPkg::microOp_t [vecExpandPkg::MAX_ELEMS-1:0] elems,
	output vecExpandPkg::elemCnt_t                          elemCount
);
	import vecExpandPkg::*;

	logic    isVector;
	mcAddr_t slotMip;

	// Builds one micro-op register field for element idx
	function automatic microReg_t expandReg(input regSpec_t spec, input elemIdx_t idx);
		microReg_t result;
		result.isVec = spec.isVec;
		// Scalar fields keep element 0 in every micro-op
		result.elemReg = {spec.regNum, spec.isVec ? idx : elemIdx_t'(0)};
		return result;
	endfunction

	// ============================================================
	// Classification
	// ============================================================

	// Any vector register field turns the whole instruction into a vector op
	assign isVector = instr.rt.isVec | instr.ra.isVec | instr.rb.isVec | instr.rc.isVec;

	// The slot number lands in the low bits of the microcode address
	assign slotMip = mip | mcAddr_t'(SLOT_INDEX);

	// A scalar op yields one micro-op, a vector op yields vl of them
	assign elemCount = isVector ? vl : elemCnt_t'(1);

	// ============================================================
	// Element micro-ops
	// ============================================================

	// All MAX_ELEMS entries are built, elemCount says how many are real
	always_comb begin
		for (int k = 0; k < MAX_ELEMS; k++) begin
			elems[k].opcode  = instr.opcode;
			elems[k].rt      = expandReg(instr.rt, elemIdx_t'(k));
			elems[k].ra      = expandReg(instr.ra, elemIdx_t'(k));
			elems[k].rb      = expandReg(instr.rb, elemIdx_t'(k));
			elems[k].rc      = expandReg(instr.rc, elemIdx_t'(k));
			// Entry 0 is the only one a scalar op uses, so its index is 0 as well
			elems[k].elemIdx = elemIdx_t'(k);
			elems[k].pc      = pc;
			elems[k].mip     = slotMip;
		end
	end

endmodule

`default_nettype wire

// File: expand/expandCompactor.sv
`timescale 1ns/1ns
`default_nettype none

module expandCompactor #(
	parameter int SLOTS = 4
) (
	input  logic                                                        clk,
	input  logic                                                        rst,
	input  logic                                                        latchValid,
	input  vecExpandPkg::microOp_t [SLOTS-1:0][vecExpandPkg::MAX_ELEMS-1:0] slotElems,
	input  vecExpandPkg::elemCnt_t [SLOTS-1:0]                          slotCounts,
	output vecExpandPkg::microOp_t [SLOTS*vecExpandPkg::MAX_ELEMS-1:0]  buffer,
	output vecExpandPkg::uopCnt_t                                       total,
	output logic                                                        bufValid
);
	import vecExpandPkg::*;

	uopCnt_t [SLOTS-1:0]                offsets;
	uopCnt_t                            nextTotal;
	microOp_t [SLOTS*MAX_ELEMS-1:0]     nextBuf;

	// ============================================================
	// Prefix offsets
	// ============================================================

	// Each slot starts right after everything the earlier slots produced
	always_comb begin : prefixSum
		uopCnt_t running;
		running = '0;
		for (int s = 0; s < SLOTS; s++) begin
			offsets[s] = running;
			running    = running + uopCnt_t'(slotCounts[s]);
		end
		nextTotal = running;
	end

	// ============================================================
	// Scatter into program order
	// ============================================================

	// Slot s element k goes to offsets[s] + k and unused tail entries stay zero
	always_comb begin
		nextBuf = '0;
		for (int s = 0; s < SLOTS; s++) begin
			for (int k = 0; k < MAX_ELEMS; k++) begin
				if (elemCnt_t'(k) < slotCounts[s])
					nextBuf[offsets[s] + uopCnt_t'(k)] = slotElems[s][k];
			end
		end
	end

	// Buffer contents only change when a fresh group has been latched
	always_ff @(posedge clk) begin
		if (latchValid) begin
			buffer <= nextBuf;
			total  <= nextTotal;
		end
	end

	// bufValid follows latchValid by one cycle
	always_ff @(posedge clk) begin
		if (rst)
			bufValid <= 1'b0;
		else
			bufValid <= latchValid;
	end

	// Counts from the expanders must never overflow the buffer
	totalInRange: assert property (@(posedge clk) disable iff (rst)
		bufValid |-> (total <= uopCnt_t'(SLOTS * MAX_ELEMS)))
		else $error("expandCompactor: total %0d exceeds buffer size", total);

endmodule

`default_nettype wire

// File: expand/microOpIssue.sv
`timescale 1ns/1ns
`default_nettype none

module microOpIssue #(
	parameter int SLOTS = 4
) (
	input  logic                                                       clk,
	input  logic                                                       rst,
	input  logic                                                       bufValid,
	input  vecExpandPkg::microOp_t [SLOTS*vecExpandPkg::MAX_ELEMS-1:0] buffer,
	input  vecExpandPkg::uopCnt_t                                      total,
	output vecExpandPkg::microOp_t                                     uop,
	output logic                                                       uopValid,
	output logic                                                       doneStrobe
);
	import vecExpandPkg::*;

	typedef enum logic {
		IDLE,
		ISSUE
	} issueState_t;

	issueState_t state;
	uopCnt_t     index;
	logic        emptyDone;
	logic        lastUop;

	// ============================================================
	// Issue FSM
	// ============================================================

	assign lastUop = (index == total - uopCnt_t'(1));

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= IDLE;
			index     <= '0;
			emptyDone <= 1'b0;
		end else begin
			emptyDone <= 1'b0;
			case (state)
				IDLE: begin
					index <= '0;
					if (bufValid) begin
						// An empty group still has to be released, one cycle later
						if (total == '0)
							emptyDone <= 1'b1;
						else
							state <= ISSUE;
					end
				end
				ISSUE: begin
					if (lastUop) begin
						state <= IDLE;
						index <= '0;
					end else begin
						index <= index + uopCnt_t'(1);
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// One buffer entry per cycle straight out of the registered buffer
	assign uopValid = (state == ISSUE);
	assign uop      = buffer[index];

	// The group ends with its last micro-op, or on its own when it was empty
	assign doneStrobe = (uopValid && lastUop) || emptyDone;

	// The latch holds off new groups, so a buffer never lands mid-issue
	noBufferDuringIssue: assert property (@(posedge clk) disable iff (rst)
		bufValid |-> (state == IDLE) && !emptyDone)
		else $error("microOpIssue: buffer loaded while issuing");

endmodule

`default_nettype wire

// File: source/vecExpandTop.sv
`timescale 1ns/1ns
`default_nettype none

module vecExpandTop #(
	parameter int SLOTS = 4
) (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic                                 groupValid,
	input  vecExpandPkg::vecLen_t                vl,
	input  vecExpandPkg::mcAddr_t                mip,
	input  vecExpandPkg::pcAddr_t  [SLOTS-1:0]   pcs,
	input  vecExpandPkg::exInstr_t [SLOTS-1:0]   instrs,
	output vecExpandPkg::microOp_t               uop,
	output logic                                 uopValid,
	output logic                                 busy
);
	import vecExpandPkg::*;

	logic                              latchValid;
	elemCnt_t                          latVl;
	mcAddr_t                           latMip;
	pcAddr_t  [SLOTS-1:0]              latPcs;
	exInstr_t [SLOTS-1:0]              latInstrs;
	logic                              inFlight;
	microOp_t [SLOTS-1:0][MAX_ELEMS-1:0] slotElems;
	elemCnt_t [SLOTS-1:0]              slotCounts;
	microOp_t [SLOTS*MAX_ELEMS-1:0]    buffer;
	uopCnt_t                           total;
	logic                              bufValid;
	logic                              doneStrobe;

	// ============================================================
	// Group latch and slot expanders
	// ============================================================

	groupLatch #(.SLOTS(SLOTS)) groupLatch_i (
		.clk(clk), .rst(rst), .groupValid(groupValid), .vl(vl), .mip(mip),
		.pcs(pcs), .instrs(instrs), .doneStrobe(doneStrobe),
		.latchValid(latchValid), .latVl(latVl), .latMip(latMip),
		.latPcs(latPcs), .latInstrs(latInstrs), .inFlight(inFlight)
	);

	for (genvar s = 0; s < SLOTS; s++) begin : slotGen
		slotExpander #(.SLOT_INDEX(s)) slotExpander_i (
			.instr(latInstrs[s]), .pc(latPcs[s]), .mip(latMip), .vl(latVl),
			.elems(slotElems[s]), .elemCount(slotCounts[s])
		);
	end

	// ============================================================
	// Buffer and issue
	// ============================================================

	expandCompactor #(.SLOTS(SLOTS)) expandCompactor_i (
		.clk(clk), .rst(rst), .latchValid(latchValid),
		.slotElems(slotElems), .slotCounts(slotCounts),
		.buffer(buffer), .total(total), .bufValid(bufValid)
	);

	microOpIssue #(.SLOTS(SLOTS)) microOpIssue_i (
		.clk(clk), .rst(rst), .bufValid(bufValid), .buffer(buffer), .total(total),
		.uop(uop), .uopValid(uopValid), .doneStrobe(doneStrobe)
	);

	// An empty group releases without a micro-op, busy drops in that same cycle
	assign busy = inFlight && !(doneStrobe && !uopValid);

endmodule

`default_nettype wire

// File: bench/vecExpandTb.sv
`timescale 1ns/1ns
`default_nettype none

module vecExpandTb;
	import vecExpandPkg::*;

	localparam int SLOTS = 4;
	localparam int DIRECTED_GROUPS = 17;
	localparam int RANDOM_GROUPS = 200;
	// Every group gets a budget of 100 cycles, the extra 200 cover reset and the drain
	localparam int TIMEOUT_CYCLES = 100 * (DIRECTED_GROUPS + RANDOM_GROUPS) + 200;

	typedef exInstr_t [SLOTS-1:0] instrGroup_t;
	typedef pcAddr_t [SLOTS-1:0] pcGroup_t;

	logic        clk = 1'b0;
	logic        rst;
	logic        groupValid;
	vecLen_t     vl;
	mcAddr_t     mip;
	pcGroup_t    pcs;
	instrGroup_t instrs;
	microOp_t    uop;
	logic        uopValid;
	logic        busy;

	// Reference model state, owned by the scoreboard block below
	microOp_t    expQ[$];
	microOp_t    expHead;
	int          expLeft;
	int          grpCount;
	int          cycleCount = 0;
	string       testName = "reset";
	logic [31:0] rngState = 32'h8a13;

	vecExpandTop #(.SLOTS(SLOTS)) vecExpandTop_i (
		.clk(clk), .rst(rst), .groupValid(groupValid), .vl(vl), .mip(mip),
		.pcs(pcs), .instrs(instrs), .uop(uop), .uopValid(uopValid), .busy(busy)
	);

	always #10 clk = ~clk;

	// ============================================================
	// Reporting and helpers
	// ============================================================

	task automatic reportProblem(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic reportMismatch(input string what, input logic [127:0] expVal,
			input logic [127:0] actVal);
		reportProblem($sformatf("FAILED %s %s expected %0h actual %0h",
			testName, what, expVal, actVal));
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	task automatic drawRandom(output logic [31:0] value);
		rngState = xorshift(rngState);
		value = rngState;
	endtask

	// Flags and registers are ordered rt, ra, rb, rc from the top bits down
	function automatic exInstr_t mkInstr(input logic [15:0] op, input logic [3:0] flags,
			input logic [23:0] regs);
		exInstr_t ins;
		ins.opcode = op;
		ins.rt = regSpec_t'{flags[3], regs[23:18]};
		ins.ra = regSpec_t'{flags[2], regs[17:12]};
		ins.rb = regSpec_t'{flags[1], regs[11:6]};
		ins.rc = regSpec_t'{flags[0], regs[5:0]};
		return ins;
	endfunction

	// Nibble s of flagSet gives the vector flags of slot s, registers differ per slot
	function automatic instrGroup_t patternGroup(input logic [15:0] baseOp,
			input logic [15:0] flagSet);
		instrGroup_t grp;
		for (int s = 0; s < SLOTS; s++) begin
			grp[s] = mkInstr(baseOp + 16'(s), flagSet[4 * (s % 4) +: 4],
				{archReg_t'(s + 1), archReg_t'(s + 9), archReg_t'(s + 17), archReg_t'(s + 25)});
		end
		return grp;
	endfunction

	function automatic pcGroup_t pcsFrom(input pcAddr_t base);
		pcGroup_t p;
		for (int s = 0; s < SLOTS; s++)
			p[s] = base + 32'(4 * s);
		return p;
	endfunction

	// ============================================================
	// Reference model
	// ============================================================

	// Vector fields get the element number appended, scalar fields get zero
	function automatic microReg_t elemField(input regSpec_t r, input int k);
		microReg_t m;
		m.isVec = r.isVec;
		m.elemReg = r.isVec ? {r.regNum, elemIdx_t'(k)} : {r.regNum, 3'b000};
		return m;
	endfunction

	task automatic modelGroup(input vecLen_t vlIn, input mcAddr_t mipIn,
			input pcGroup_t pcsIn, input instrGroup_t instrsIn, output int count);
		int limit;
		int elems;
		exInstr_t ins;
		microOp_t u;
		count = 0;
		limit = (vlIn > 5'd8) ? 8 : int'(vlIn);
		for (int s = 0; s < SLOTS; s++) begin
			ins = instrsIn[s];
			elems = (ins.rt.isVec || ins.ra.isVec || ins.rb.isVec || ins.rc.isVec) ? limit : 1;
			for (int k = 0; k < elems; k++) begin
				u.opcode = ins.opcode;
				u.rt = elemField(ins.rt, k);
				u.ra = elemField(ins.ra, k);
				u.rb = elemField(ins.rb, k);
				u.rc = elemField(ins.rc, k);
				u.elemIdx = elemIdx_t'(k);
				u.pc = pcsIn[s];
				u.mip = mipIn | mcAddr_t'(s);
				expQ.push_back(u);
				count++;
			end
		end
	endtask

	// Watches the input strobe and the issued micro-ops, pushes and pops the model queue
	always @(posedge clk) begin : scoreboard
		int count;
		if (rst) begin
			expQ.delete();
			grpCount = 0;
		end else begin
			if (uopValid && expQ.size() > 0)
				void'(expQ.pop_front());
			if (groupValid) begin
				modelGroup(vl, mip, pcs, instrs, count);
				grpCount = count;
			end
		end
		expLeft = expQ.size();
		expHead = (expLeft > 0) ? expQ[0] : '0;
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES)
			reportProblem($sformatf("Timeout after %0d cycles, the DUT never went idle",
				cycleCount));
	end

	// ============================================================
	// Checks
	// ============================================================

	resetState: assert property (@(posedge clk) $fell(rst) |-> !busy && !uopValid)
		else reportProblem("busy or uopValid is high right after reset");

	noExtraUop: assert property (@(posedge clk) disable iff (rst)
		uopValid |-> expLeft > 0)
		else reportProblem($sformatf("Micro-op issued in %s although none was expected", testName));

	uopMatch: assert property (@(posedge clk) disable iff (rst)
		(uopValid && expLeft > 0) |-> uop == expHead)
		else reportMismatch("micro-op", 128'($sampled(expHead)), 128'($sampled(uop)));

	// First micro-op three cycles after the strobe, none at all for an empty group
	firstUop: assert property (@(posedge clk) disable iff (rst)
		$past(groupValid, 3) |-> uopValid == (grpCount != 0))
		else reportMismatch("uopValid at strobe plus 3", 128'($sampled(grpCount != 0)),
			128'($sampled(uopValid)));

	busyRise: assert property (@(posedge clk) disable iff (rst)
		$past(groupValid) |-> busy)
		else reportMismatch("busy after strobe", 128'(1), 128'($sampled(busy)));

	uopWhileBusy: assert property (@(posedge clk) disable iff (rst)
		uopValid |-> busy)
		else reportMismatch("busy during issue", 128'(1), 128'($sampled(busy)));

	busyFall: assert property (@(posedge clk) disable iff (rst)
		$past(uopValid && expLeft == 1) |-> !busy && !uopValid)
		else reportMismatch("busy after last micro-op", 128'(0), 128'($sampled(busy)));

	emptyRelease: assert property (@(posedge clk) disable iff (rst)
		($past(groupValid, 3) && grpCount == 0) |-> !busy)
		else reportMismatch("busy for empty group", 128'(0), 128'($sampled(busy)));

	// ============================================================
	// Stimulus
	// ============================================================

	task automatic waitIdle();
		do
			@(negedge clk);
		while (busy);
	endtask

	task automatic sendGroup(input string name, input vecLen_t vlIn, input mcAddr_t mipIn,
			input pcGroup_t pcsIn, input instrGroup_t instrsIn);
		waitIdle();
		@(posedge clk);
		testName = name;
		groupValid <= 1'b1;
		vl <= vlIn;
		mip <= mipIn;
		pcs <= pcsIn;
		instrs <= instrsIn;
		@(posedge clk);
		groupValid <= 1'b0;
	endtask

	initial begin : stimulus
		logic [31:0] rnd;
		logic [31:0] rndRegs;
		logic [3:0]  flags;
		instrGroup_t grp;
		pcGroup_t    randPcs;
		vecLen_t     randVl;
		rst = 1'b1;
		groupValid = 1'b0;
		vl = '0;
		mip = '0;
		pcs = '0;
		instrs = '0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;

		sendGroup("allScalar", 5'd5, 12'h100, pcsFrom(32'h1000), patternGroup(16'h0a00, 16'h0000));
		// Slot 0 vectors rt only, slot 1 is scalar, slot 2 ra and rb, slot 3 everything
		for (int v = 1; v <= 8; v++)
			sendGroup("vectorLength", vecLen_t'(v), mcAddr_t'(v << 4),
				pcsFrom(32'h2000 + 32'(v * 64)), patternGroup(16'h0b00, 16'hf608));
		for (int i = 0; i < 4; i++)
			sendGroup("clampLength", vecLen_t'((i == 3) ? 31 : 9 + 7 * i), 12'h200,
				pcsFrom(32'h4000), patternGroup(16'h0c00, 16'hf608));
		sendGroup("zeroLengthMixed", 5'd0, 12'h300, pcsFrom(32'h5000), patternGroup(16'h0d00, 16'hf608));
		sendGroup("zeroLengthVector", 5'd0, 12'h310, pcsFrom(32'h5100), patternGroup(16'h0d80, 16'h1248));
		// Low mip bits already set, so the slot OR shows up only in some slots
		sendGroup("slotTag", 5'd3, 12'h5a5, pcsFrom(32'hbeef_0000), patternGroup(16'h0e00, 16'hf608));
		sendGroup("latency", 5'd2, 12'h00c, pcsFrom(32'h3000), patternGroup(16'h0f00, 16'h1248));

		// About one field in four is a vector register, half the lengths stay within 8
		for (int g = 0; g < RANDOM_GROUPS; g++) begin
			for (int s = 0; s < SLOTS; s++) begin
				drawRandom(rnd);
				drawRandom(rndRegs);
				flags = {&rnd[17:16], &rnd[19:18], &rnd[21:20], &rnd[23:22]};
				grp[s] = mkInstr(rnd[15:0], flags, rndRegs[23:0]);
				drawRandom(rnd);
				randPcs[s] = rnd;
			end
			drawRandom(rnd);
			randVl = rnd[5] ? vecLen_t'(rnd[4:0] % 5'd9) : rnd[4:0];
			sendGroup("random", randVl, rnd[27:16], randPcs, grp);
		end

		waitIdle();
		repeat (4) @(negedge clk);
		if (expQ.size() != 0) begin
			reportProblem($sformatf("%0d expected micro-ops were never issued", expQ.size()));
		end else begin
			$display("TEST PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: vecExpandTop.f
common/vecExpandPkg.sv
expand/groupLatch.sv
expand/slotExpander.sv
expand/expandCompactor.sv
expand/microOpIssue.sv
source/vecExpandTop.sv
bench/vecExpandTb.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module vecExpandTb -f vecExpandTop.f -Mdir obj_dir

./obj_dir/VvecExpandTb > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST PASSED" sim.log; then
	exit 0
else
	echo "Simulation did not pass, see sim.log"
	exit 1
fi
